/* vlog.f */
logic/axiPkg.sv
logic/cachePkg.sv
logic/refillIf.sv
logic/storeIf.sv
logic/instCache.sv
logic/dataCache.sv
logic/axiReadMaster.sv
logic/axiWriteMaster.sv
logic/cacheTop.sv
tb/cacheTb.sv

/* run.sh */
#!/usr/bin/env bash
# build and run the cache testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --top-module cacheTb -f vlog.f -o simCacheTb; then
  echo "build failed"
  exit 1
fi

if ! simOut="$(./obj_dir/simCacheTb 2>&1)"; then
  echo "$simOut"
  echo "simulation exited with an error"
  exit 1
fi
echo "$simOut"

if grep -qx "TEST PASSED" <<< "$simOut"; then
  exit 0
fi
exit 1

/* tb/cacheTb.sv */
`timescale 1ns/1ps

module cacheTb;

  localparam logic [31:0] SEED = 32'h0865_1be2;
  localparam int MEM_WORDS = 16384;
  localparam int BURST_WORDS = 16;
  localparam int TIMEOUT = 200;

  typedef enum logic [1:0] {sideInst, sideData, sideBoth} sideT;
  typedef enum logic {opRead, opStore} opT;
  typedef enum logic [1:0] {pulseInstAddr, pulseInstData, pulseDataAddr, pulseDataData} pulseT;

  typedef struct packed {
    sideT                 side;
    opT                   op;
    logic                 uncached;
    cachePkg::accessSizeT size;
    cachePkg::addrT       addr;
    cachePkg::wordT       wdata;
    logic [1:0]           arInc;
  } stimRowT;

  logic                 clk;
  logic                 resetn;
  logic                 instReq;
  cachePkg::addrT       instAddr;
  logic                 instAddrOk;
  logic                 instDataOk;
  cachePkg::wordT       instRdata;
  logic                 dataReq;
  logic                 dataWr;
  logic                 dataUncached;
  cachePkg::accessSizeT dataSize;
  cachePkg::addrT       dataAddr;
  cachePkg::wordT       dataWdata;
  logic                 dataAddrOk;
  logic                 dataDataOk;
  cachePkg::wordT       dataRdata;
  cachePkg::addrT       ARADDR;
  axiPkg::burstLenT     ARLEN;
  logic                 ARVALID;
  logic                 ARREADY = 1'b0;
  cachePkg::wordT       RDATA = '0;
  logic                 RLAST = 1'b0;
  logic                 RVALID = 1'b0;
  logic                 RREADY;
  cachePkg::addrT       AWADDR;
  logic                 AWVALID;
  logic                 AWREADY = 1'b0;
  cachePkg::wordT       WDATA;
  axiPkg::strobeT       WSTRB;
  logic                 WVALID;
  logic                 WREADY = 1'b0;
  logic                 BVALID = 1'b0;
  logic                 BREADY;

  // memory model state
  cachePkg::wordT       mem [MEM_WORDS];
  logic [31:0]          rngState;
  logic                 filled = 1'b0;
  logic                 rActive;
  cachePkg::addrT       rAddr;
  axiPkg::burstLenT     rLeft;
  cachePkg::addrT       wAddr;
  cachePkg::addrT       lastAwAddr;
  axiPkg::strobeT       lastStrb;
  int                   writeCount = 0;
  cachePkg::addrT       arAddrLog [$];
  axiPkg::burstLenT     arLenLog [$];
  stimRowT              rows [$];

  cacheTop u_dut (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  function automatic logic [31:0] nextRandom();
    rngState = rngState * 32'd1664525 + 32'd1013904223;
    return rngState;
  endfunction

  // ready about three cycles out of four
  function automatic logic readyBit();
    logic [31:0] r;
    r = nextRandom();
    return r[27] | r[26];
  endfunction

  function automatic int wordIndex(cachePkg::addrT a);
    return int'(a[15:2]);
  endfunction

  function automatic cachePkg::addrT alignDown(cachePkg::addrT a, int bytes);
    return a & ~(cachePkg::addrT'(bytes - 1));
  endfunction

  // lanes covered by the access, starting at its offset rounded down to its size
  function automatic axiPkg::strobeT laneStrobe(cachePkg::accessSizeT size, logic [1:0] off);
    int             bytes;
    int             first;
    axiPkg::strobeT strb;
    case (size)
      cachePkg::sizeByte: bytes = 1;
      cachePkg::sizeHalf: bytes = 2;
      default:            bytes = 4;
    endcase
    first = int'(off) / bytes * bytes;
    strb  = '0;
    for (int b = 0; b < 4; b++) begin
      strb[b] = (b >= first) && (b < first + bytes);
    end
    return strb;
  endfunction

  function automatic cachePkg::wordT mergeLanes(cachePkg::wordT old, cachePkg::wordT wr,
                                               axiPkg::strobeT strb);
    cachePkg::wordT res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = wr[8*b +: 8];
      end
    end
    return res;
  endfunction

  ////////////////////
  // memory model
  ////////////////////

  always @(posedge clk) begin
    if (!resetn) begin
      if (!filled) begin
        rngState = SEED;
        for (int i = 0; i < MEM_WORDS; i++) begin
          mem[i] <= nextRandom();
        end
        filled <= 1'b1;
      end
      ARREADY <= 1'b0;
      RVALID  <= 1'b0;
      RLAST   <= 1'b0;
      AWREADY <= 1'b0;
      WREADY  <= 1'b0;
      BVALID  <= 1'b0;
      rActive <= 1'b0;
    end else begin
      ARREADY <= readyBit();
      AWREADY <= readyBit();
      WREADY  <= readyBit();
      if (ARVALID && ARREADY) begin
        arAddrLog.push_back(ARADDR);
        arLenLog.push_back(ARLEN);
        rAddr   <= ARADDR;
        rLeft   <= ARLEN;
        rActive <= 1'b1;
      end
      // one beat at a time, incrementing
      if (rActive) begin
        if (RVALID && RREADY) begin
          RVALID <= 1'b0;
          RLAST  <= 1'b0;
          rAddr  <= rAddr + 32'd4;
          rLeft  <= rLeft - 8'd1;
          if (RLAST) begin
            rActive <= 1'b0;
          end
        end else if (!RVALID && readyBit()) begin
          RVALID <= 1'b1;
          RDATA  <= mem[wordIndex(rAddr)];
          RLAST  <= (rLeft == 8'd0);
        end
      end
      if (AWVALID && AWREADY) begin
        wAddr <= AWADDR;
      end
      if (WVALID && WREADY) begin
        for (int b = 0; b < 4; b++) begin
          if (WSTRB[b]) begin
            mem[wordIndex(wAddr)][8*b +: 8] <= WDATA[8*b +: 8];
          end
        end
        lastAwAddr <= wAddr;
        lastStrb   <= WSTRB;
        BVALID     <= 1'b1;
      end
      if (BVALID && BREADY) begin
        BVALID     <= 1'b0;
        writeCount <= writeCount + 1;
      end
    end
  end

  ////////////////////
  // checks
  ////////////////////

  task automatic failNow(input string line);
    $display("%s", line);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic checkWord(input string name, input cachePkg::wordT got,
                           input cachePkg::wordT exp);
    if (got !== exp) begin
      failNow($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic checkStrobe(input string name, input axiPkg::strobeT got,
                             input axiPkg::strobeT exp);
    if (got !== exp) begin
      failNow($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic checkAddr(input string name, input cachePkg::addrT got,
                           input cachePkg::addrT exp);
    if (got !== exp) begin
      failNow($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  task automatic checkLen(input string name, input axiPkg::burstLenT got,
                          input axiPkg::burstLenT exp);
    if (got !== exp) begin
      failNow($sformatf("FAILED %s: got %h, expected %h", name, got, exp));
    end
  endtask

  ////////////////////
  // request driving
  ////////////////////

  function automatic logic pulseHigh(pulseT which);
    case (which)
      pulseInstAddr: return instAddrOk;
      pulseInstData: return instDataOk;
      pulseDataAddr: return dataAddrOk;
      default:       return dataDataOk;
    endcase
  endfunction

  // cycles counts the falling edges until the pulse shows
  task automatic waitPulse(input pulseT which, input string what, output int cycles);
    bit seen;
    seen = 1'b0;
    cycles = 0;
    while (!seen && cycles < TIMEOUT) begin
      @(negedge clk);
      cycles++;
      seen = pulseHigh(which);
    end
    if (!seen) begin
      failNow($sformatf("timed out waiting for %s", what));
    end
  endtask

  task automatic waitWrites(input int target);
    int n;
    n = 0;
    while (writeCount < target && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (writeCount < target) begin
      failNow("timed out waiting for the write response");
    end
  endtask

  task automatic issueInst(input cachePkg::addrT addr, output cachePkg::wordT got,
                           output int latency);
    int waited;
    @(posedge clk);
    instReq  <= 1'b1;
    instAddr <= addr;
    waitPulse(pulseInstAddr, "instruction addrOk", waited);
    @(posedge clk);
    instReq <= 1'b0;
    waitPulse(pulseInstData, "instruction dataOk", latency);
    got = instRdata;
  endtask

  task automatic issueData(input stimRowT row, output cachePkg::wordT got,
                           output int latency);
    int waited;
    @(posedge clk);
    dataReq      <= 1'b1;
    dataWr       <= (row.op == opStore);
    dataUncached <= row.uncached;
    dataSize     <= row.size;
    dataAddr     <= row.addr;
    dataWdata    <= row.wdata;
    waitPulse(pulseDataAddr, "data addrOk", waited);
    @(posedge clk);
    dataReq <= 1'b0;
    waitPulse(pulseDataData, "data dataOk", latency);
    got = dataRdata;
  endtask

  task automatic applyRow(input stimRowT row);
    int             arBase;
    int             wrBase;
    int             latency;
    int             instLatency;
    cachePkg::wordT got;
    cachePkg::wordT instGot;
    cachePkg::addrT mirror;
    axiPkg::strobeT expStrb;
    cachePkg::wordT expMerged;
    arBase    = arAddrLog.size();
    wrBase    = writeCount;
    // paired fetch goes to the upper half of the model memory
    mirror    = row.addr ^ 32'h0000_8000;
    expStrb   = laneStrobe(row.size, row.addr[1:0]);
    expMerged = mergeLanes(mem[wordIndex(row.addr)], row.wdata, expStrb);
    case (row.side)
      sideInst: begin
        issueInst(row.addr, got, latency);
        checkWord("instRdata", got, mem[wordIndex(row.addr)]);
      end
      sideData: begin
        issueData(row, got, latency);
        if (row.op == opRead) begin
          checkWord("dataRdata", got, mem[wordIndex(row.addr)]);
        end
      end
      default: begin
        fork
          issueInst(mirror, instGot, instLatency);
          issueData(row, got, latency);
        join
        checkWord("instRdata", instGot, mem[wordIndex(mirror)]);
        checkWord("dataRdata", got, mem[wordIndex(row.addr)]);
      end
    endcase
    if (arAddrLog.size() - arBase != int'(row.arInc)) begin
      failNow($sformatf("FAILED AR count: got %h, expected %h",
                        arAddrLog.size() - arBase, row.arInc));
    end
    if (row.arInc == 2'd0 && row.side != sideBoth && latency != 2) begin
      failNow($sformatf("FAILED hit latency: got %h, expected %h", latency, 2));
    end
    if (row.arInc != 2'd0) begin
      if (row.side == sideInst) begin
        checkAddr("ARADDR", arAddrLog[arBase], alignDown(row.addr, 4 * BURST_WORDS));
        checkLen("ARLEN", arLenLog[arBase], axiPkg::burstLenT'(BURST_WORDS - 1));
      end else begin
        // data side first, even on a tie
        checkAddr("ARADDR", arAddrLog[arBase], alignDown(row.addr, 4));
        checkLen("ARLEN", arLenLog[arBase], 8'd0);
      end
      if (row.side == sideBoth) begin
        checkAddr("ARADDR", arAddrLog[arBase + 1], alignDown(mirror, 4 * BURST_WORDS));
        checkLen("ARLEN", arLenLog[arBase + 1], axiPkg::burstLenT'(BURST_WORDS - 1));
      end
    end
    if (row.op == opStore) begin
      waitWrites(wrBase + 1);
      checkAddr("AWADDR", lastAwAddr, alignDown(row.addr, 4));
      checkStrobe("WSTRB", lastStrb, expStrb);
      checkWord("memory", mem[wordIndex(row.addr)], expMerged);
    end else if (writeCount != wrBase) begin
      failNow($sformatf("FAILED write count: got %h, expected %h", writeCount, wrBase));
    end
  endtask

  ////////////////////
  // stimulus table
  ////////////////////

  function automatic void addRow(sideT side, opT op, logic uncached,
                                 cachePkg::accessSizeT size, cachePkg::addrT addr,
                                 cachePkg::wordT wdata, int arInc);
    stimRowT r;
    r.side     = side;
    r.op       = op;
    r.uncached = uncached;
    r.size     = size;
    r.addr     = addr;
    r.wdata    = wdata;
    r.arInc    = 2'(arInc);
    rows.push_back(r);
  endfunction

  function automatic void buildRows();
    // fetch miss, then the rest of the block hits
    addRow(sideInst, opRead,  1'b0, cachePkg::sizeWord, 32'h0000_1048, 32'h0, 1);
    addRow(sideInst, opRead,  1'b0, cachePkg::sizeWord, 32'h0000_1040, 32'h0, 0);
    addRow(sideInst, opRead,  1'b0, cachePkg::sizeWord, 32'h0000_107C, 32'h0, 0);
    addRow(sideInst, opRead,  1'b0, cachePkg::sizeWord, 32'h0000_1060, 32'h0, 0);
    // miss, hit, eviction 4 KiB away, miss again
    addRow(sideData, opRead,  1'b0, cachePkg::sizeWord, 32'h0000_2004, 32'h0, 1);
    addRow(sideData, opRead,  1'b0, cachePkg::sizeWord, 32'h0000_2004, 32'h0, 0);
    addRow(sideData, opRead,  1'b0, cachePkg::sizeWord, 32'h0000_3004, 32'h0, 1);
    addRow(sideData, opRead,  1'b0, cachePkg::sizeWord, 32'h0000_2004, 32'h0, 1);
    // stores on hit and on miss, each read back
    addRow(sideData, opStore, 1'b0, cachePkg::sizeByte, 32'h0000_2005, 32'hA1B2_C3D4, 0);
    addRow(sideData, opRead,  1'b0, cachePkg::sizeWord, 32'h0000_2004, 32'h0, 0);
    addRow(sideData, opStore, 1'b0, cachePkg::sizeHalf, 32'h0000_300E, 32'h5566_7788, 0);
    addRow(sideData, opRead,  1'b0, cachePkg::sizeWord, 32'h0000_300C, 32'h0, 1);
    addRow(sideData, opStore, 1'b0, cachePkg::sizeByte, 32'h0000_300F, 32'h9ABC_DEF0, 0);
    addRow(sideData, opRead,  1'b0, cachePkg::sizeWord, 32'h0000_300C, 32'h0, 0);
    addRow(sideData, opStore, 1'b0, cachePkg::sizeHalf, 32'h0000_3000, 32'h2468_ACE0, 0);
    addRow(sideData, opStore, 1'b0, cachePkg::sizeWord, 32'h0000_2008, 32'h1357_9BDF, 0);
    addRow(sideData, opRead,  1'b0, cachePkg::sizeWord, 32'h0000_2008, 32'h0, 1);
    // uncached reads always go to the bus
    addRow(sideData, opRead,  1'b1, cachePkg::sizeWord, 32'h0000_4010, 32'h0, 1);
    addRow(sideData, opStore, 1'b0, cachePkg::sizeWord, 32'h0000_4010, 32'hCAFE_F00D, 0);
    addRow(sideData, opRead,  1'b1, cachePkg::sizeWord, 32'h0000_4010, 32'h0, 1);
    addRow(sideData, opRead,  1'b1, cachePkg::sizeWord, 32'h0000_4010, 32'h0, 1);
    // no fill from the uncached reads
    addRow(sideData, opRead,  1'b0, cachePkg::sizeWord, 32'h0000_4010, 32'h0, 1);
    // both sides miss in the same cycle
    addRow(sideBoth, opRead,  1'b0, cachePkg::sizeWord, 32'h0000_5020, 32'h0, 2);
  endfunction

  initial begin
    resetn       = 1'b0;
    instReq      = 1'b0;
    instAddr     = '0;
    dataReq      = 1'b0;
    dataWr       = 1'b0;
    dataUncached = 1'b0;
    dataSize     = cachePkg::sizeWord;
    dataAddr     = '0;
    dataWdata    = '0;
    buildRows();
    repeat (4) @(posedge clk);
    resetn <= 1'b1;
    foreach (rows[i]) begin
      applyRow(rows[i]);
    end
    $display("TEST PASSED");
    $finish;
  end

endmodule

/* logic/cacheTop.sv */
`timescale 1ns/1ps

module cacheTop #(
  parameter int I_INDEX_W = 10,
  parameter int D_INDEX_W = 10,
  parameter int BURST_LEN = 16
) (
  input  logic                 clk,
  input  logic                 resetn,
  // instruction side
  input  logic                 instReq,
  input  cachePkg::addrT       instAddr,
  output logic                 instAddrOk,
  output logic                 instDataOk,
  output cachePkg::wordT       instRdata,
  // data side
  input  logic                 dataReq,
  input  logic                 dataWr,
  input  logic                 dataUncached,
  input  cachePkg::accessSizeT dataSize,
  input  cachePkg::addrT       dataAddr,
  input  cachePkg::wordT       dataWdata,
  output logic                 dataAddrOk,
  output logic                 dataDataOk,
  output cachePkg::wordT       dataRdata,
  // AXI read
  output cachePkg::addrT       ARADDR,
  output axiPkg::burstLenT     ARLEN,
  output logic                 ARVALID,
  input  logic                 ARREADY,
  input  cachePkg::wordT       RDATA,
  input  logic                 RLAST,
  input  logic                 RVALID,
  output logic                 RREADY,
  // AXI write
  output cachePkg::addrT       AWADDR,
  output logic                 AWVALID,
  input  logic                 AWREADY,
  output cachePkg::wordT       WDATA,
  output axiPkg::strobeT       WSTRB,
  output logic                 WVALID,
  input  logic                 WREADY,
  input  logic                 BVALID,
  output logic                 BREADY
);

  refillIf instRefill ();
  refillIf dataRefill ();
  storeIf  storeBus ();

  instCache #(
    .I_INDEX_W (I_INDEX_W),
    .BURST_LEN (BURST_LEN)
  ) u_instCache (
    .clk    (clk),
    .resetn (resetn),
    .req    (instReq),
    .addr   (instAddr),
    .addrOk (instAddrOk),
    .dataOk (instDataOk),
    .rdata  (instRdata),
    .refill (instRefill.cache)
  );

  dataCache #(
    .D_INDEX_W (D_INDEX_W)
  ) u_dataCache (
    .clk      (clk),
    .resetn   (resetn),
    .req      (dataReq),
    .wr       (dataWr),
    .uncached (dataUncached),
    .size     (dataSize),
    .addr     (dataAddr),
    .wdata    (dataWdata),
    .addrOk   (dataAddrOk),
    .dataOk   (dataDataOk),
    .rdata    (dataRdata),
    .refill   (dataRefill.cache),
    .store    (storeBus.cache)
  );

  axiReadMaster #(
    .BURST_LEN (BURST_LEN)
  ) u_axiReadMaster (
    .clk     (clk),
    .resetn  (resetn),
    .ARREADY (ARREADY),
    .RVALID  (RVALID),
    .RLAST   (RLAST),
    .RDATA   (RDATA),
    .ARADDR  (ARADDR),
    .ARLEN   (ARLEN),
    .ARVALID (ARVALID),
    .RREADY  (RREADY),
    .inst    (instRefill.master),
    .data    (dataRefill.master)
  );

  axiWriteMaster u_axiWriteMaster (
    .clk     (clk),
    .resetn  (resetn),
    .AWREADY (AWREADY),
    .WREADY  (WREADY),
    .BVALID  (BVALID),
    .AWADDR  (AWADDR),
    .AWVALID (AWVALID),
    .WDATA   (WDATA),
    .WSTRB   (WSTRB),
    .WVALID  (WVALID),
    .BREADY  (BREADY),
    .store   (storeBus.master)
  );

endmodule

/* logic/axiWriteMaster.sv */
`timescale 1ns/1ps

module axiWriteMaster (
  input  logic            clk,
  input  logic            resetn,
  input  logic            AWREADY,
  input  logic            WREADY,
  input  logic            BVALID,
  output cachePkg::addrT  AWADDR,
  output logic            AWVALID,
  output cachePkg::wordT  WDATA,
  output axiPkg::strobeT  WSTRB,
  output logic            WVALID,
  output logic            BREADY,
  storeIf.master          store
);

  axiPkg::writeStateT state;

  assign AWVALID    = (state == axiPkg::writeAddr);
  assign WVALID     = (state == axiPkg::writeData);
  assign BREADY     = (state == axiPkg::writeResp);
  assign store.busy = (state != axiPkg::writeIdle);

  // one phase after the other
  always_ff @(posedge clk) begin
    if (!resetn) begin
      state <= axiPkg::writeIdle;
    end else begin
      case (state)
        axiPkg::writeIdle: if (store.valid) state <= axiPkg::writeAddr;
        axiPkg::writeAddr: if (AWREADY) state <= axiPkg::writeData;
        axiPkg::writeData: if (WREADY) state <= axiPkg::writeResp;
        axiPkg::writeResp: if (BVALID) state <= axiPkg::writeIdle;
        default:           state <= axiPkg::writeIdle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == axiPkg::writeIdle && store.valid) begin
      AWADDR <= store.addr;
      WDATA  <= store.data;
      WSTRB  <= store.strobe;
    end
  end

endmodule

/* logic/axiReadMaster.sv */
`timescale 1ns/1ps

module axiReadMaster #(
  parameter int BURST_LEN = 16
) (
  input  logic              clk,
  input  logic              resetn,
  input  logic              ARREADY,
  input  logic              RVALID,
  input  logic              RLAST,
  input  cachePkg::wordT    RDATA,
  output cachePkg::addrT    ARADDR,
  output axiPkg::burstLenT  ARLEN,
  output logic              ARVALID,
  output logic              RREADY,
  refillIf.master           inst,
  refillIf.master           data
);

  localparam axiPkg::burstLenT FULL_LEN = axiPkg::burstLenT'(BURST_LEN - 1);

  axiPkg::readStateT state;
  // set while the data side owns the bus
  logic              grantData;

  assign ARVALID = (state == axiPkg::readAddr);
  assign RREADY  = (state == axiPkg::readData);

  // beats only reach the granted side
  assign inst.beatValid = RREADY && RVALID && !grantData;
  assign inst.beatData  = RDATA;
  assign inst.beatLast  = RLAST;
  assign data.beatValid = RREADY && RVALID && grantData;
  assign data.beatData  = RDATA;
  assign data.beatLast  = RLAST;

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state     <= axiPkg::readIdle;
      grantData <= 1'b0;
    end else begin
      case (state)
        axiPkg::readIdle: begin
          // data side wins a tie
          if (data.req) begin
            grantData <= 1'b1;
            state     <= axiPkg::readAddr;
          end else if (inst.req) begin
            grantData <= 1'b0;
            state     <= axiPkg::readAddr;
          end
        end
        axiPkg::readAddr: begin
          if (ARREADY) begin
            state <= axiPkg::readData;
          end
        end
        axiPkg::readData: begin
          if (RVALID && RLAST) begin
            state <= axiPkg::readStall;
          end
        end
        default: state <= axiPkg::readIdle;
      endcase
    end
  end

  // address phase payload, taken with the grant
  always_ff @(posedge clk) begin
    if (state == axiPkg::readIdle) begin
      if (data.req) begin
        ARADDR <= data.addr;
        ARLEN  <= data.burst ? FULL_LEN : '0;
      end else if (inst.req) begin
        ARADDR <= inst.addr;
        ARLEN  <= inst.burst ? FULL_LEN : '0;
      end
    end
  end

endmodule

/* logic/dataCache.sv */
`timescale 1ns/1ps

module dataCache #(
  parameter int D_INDEX_W = 10
) (
  input  logic                 clk,
  input  logic                 resetn,
  input  logic                 req,
  input  logic                 wr,
  input  logic                 uncached,
  input  cachePkg::accessSizeT size,
  input  cachePkg::addrT       addr,
  input  cachePkg::wordT       wdata,
  output logic                 addrOk,
  output logic                 dataOk,
  output cachePkg::wordT       rdata,
  refillIf.cache               refill,
  storeIf.cache                store
);

  localparam int ENTRIES = 1 << D_INDEX_W;
  localparam int TAG_W = cachePkg::ADDR_W - cachePkg::OFFSET_W - D_INDEX_W;
  localparam int LANES = $bits(axiPkg::strobeT);

  cachePkg::cacheStateT          state;
  cachePkg::addrT                reqAddr;
  cachePkg::wordT                reqWdata;
  cachePkg::accessSizeT          reqSize;
  logic                          reqWr;
  logic                          reqUncached;
  logic [D_INDEX_W-1:0]          reqIndex;
  logic [TAG_W-1:0]              reqTag;
  logic [cachePkg::OFFSET_W-1:0] reqOffset;
  axiPkg::strobeT                strobe;
  logic                          hit;

  logic [ENTRIES-1:0]            valid;
  logic [TAG_W-1:0]              tags [ENTRIES];
  cachePkg::wordT                words [ENTRIES];

  assign reqOffset = reqAddr[cachePkg::OFFSET_W-1:0];
  assign reqIndex  = reqAddr[cachePkg::OFFSET_W +: D_INDEX_W];
  assign reqTag    = reqAddr[cachePkg::ADDR_W-1 -: TAG_W];
  assign hit       = valid[reqIndex] && (tags[reqIndex] == reqTag);

  // byte lanes touched by the store
  always_comb begin
    case (reqSize)
      cachePkg::sizeByte: strobe = axiPkg::strobeT'(1) << reqOffset;
      cachePkg::sizeHalf: strobe = reqOffset[1] ? 4'b1100 : 4'b0011;
      default:            strobe = '1;
    endcase
  end

  // reads and stores both go out word aligned
  assign refill.addr  = {reqAddr[cachePkg::ADDR_W-1:cachePkg::OFFSET_W],
                         {cachePkg::OFFSET_W{1'b0}}};
  assign refill.burst = 1'b0;
  assign store.addr   = refill.addr;
  assign store.data   = reqWdata;
  assign store.strobe = strobe;

  ////////////////////
  // control FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state       <= cachePkg::cacheIdle;
      addrOk      <= 1'b0;
      dataOk      <= 1'b0;
      refill.req  <= 1'b0;
      store.valid <= 1'b0;
      valid       <= '0;
    end else begin
      addrOk      <= 1'b0;
      dataOk      <= 1'b0;
      store.valid <= 1'b0;
      case (state)
        cachePkg::cacheIdle: begin
          if (req) begin
            addrOk <= 1'b1;
            state  <= cachePkg::cacheLookup;
          end
        end
        cachePkg::cacheLookup: begin
          if (reqWr) begin
            // hold here while the previous store drains
            if (!store.busy) begin
              store.valid <= 1'b1;
              state       <= cachePkg::cacheRespond;
            end
          end else if (hit && !reqUncached) begin
            state <= cachePkg::cacheRespond;
          end else begin
            refill.req <= 1'b1;
            state      <= cachePkg::cacheRefill;
          end
        end
        cachePkg::cacheRefill: begin
          if (refill.beatValid) begin
            if (!reqUncached) begin
              valid[reqIndex] <= 1'b1;
            end
            if (refill.beatLast) begin
              refill.req <= 1'b0;
              state      <= cachePkg::cacheRespond;
            end
          end
        end
        cachePkg::cacheRespond: begin
          dataOk <= 1'b1;
          state  <= cachePkg::cacheIdle;
        end
        default: state <= cachePkg::cacheIdle;
      endcase
    end
  end

  ////////////////////
  // storage and data path
  ////////////////////

  always_ff @(posedge clk) begin
    case (state)
      cachePkg::cacheIdle: begin
        if (req) begin
          reqAddr     <= addr;
          reqWdata    <= wdata;
          reqSize     <= size;
          reqWr       <= wr;
          reqUncached <= uncached;
        end
      end
      cachePkg::cacheLookup: begin
        rdata <= words[reqIndex];
        // no write allocate, merge on hit only
        if (reqWr && !store.busy && hit) begin
          for (int b = 0; b < LANES; b++) begin
            if (strobe[b]) begin
              words[reqIndex][8*b +: 8] <= reqWdata[8*b +: 8];
            end
          end
        end
      end
      cachePkg::cacheRefill: begin
        if (refill.beatValid) begin
          rdata <= refill.beatData;
          if (!reqUncached) begin
            tags[reqIndex]  <= reqTag;
            words[reqIndex] <= refill.beatData;
          end
        end
      end
      default: ;
    endcase
  end

endmodule

/* logic/instCache.sv */
`timescale 1ns/1ps

module instCache #(
  parameter int I_INDEX_W = 10,
  parameter int BURST_LEN = 16
) (
  input  logic           clk,
  input  logic           resetn,
  input  logic           req,
  input  cachePkg::addrT addr,
  output logic           addrOk,
  output logic           dataOk,
  output cachePkg::wordT rdata,
  refillIf.cache         refill
);

  localparam int ENTRIES = 1 << I_INDEX_W;
  localparam int TAG_W = cachePkg::ADDR_W - cachePkg::OFFSET_W - I_INDEX_W;
  localparam int BLOCK_W = $clog2(BURST_LEN);
  localparam int ALIGN_W = cachePkg::OFFSET_W + BLOCK_W;

  cachePkg::cacheStateT state;
  cachePkg::addrT       reqAddr;
  logic [I_INDEX_W-1:0] reqIndex;
  logic [TAG_W-1:0]     reqTag;
  logic [I_INDEX_W-1:0] fillIndex;
  logic                 hit;

  logic [ENTRIES-1:0]   valid;
  logic [TAG_W-1:0]     tags [ENTRIES];
  cachePkg::wordT       words [ENTRIES];

  assign reqIndex = reqAddr[cachePkg::OFFSET_W +: I_INDEX_W];
  assign reqTag   = reqAddr[cachePkg::ADDR_W-1 -: TAG_W];
  assign hit      = valid[reqIndex] && (tags[reqIndex] == reqTag);

  // whole block, aligned down to BURST_LEN words
  assign refill.addr  = {reqAddr[cachePkg::ADDR_W-1:ALIGN_W], {ALIGN_W{1'b0}}};
  assign refill.burst = 1'b1;

  ////////////////////
  // control FSM
  ////////////////////

  always_ff @(posedge clk) begin
    if (!resetn) begin
      state      <= cachePkg::cacheIdle;
      addrOk     <= 1'b0;
      dataOk     <= 1'b0;
      refill.req <= 1'b0;
      valid      <= '0;
    end else begin
      addrOk <= 1'b0;
      dataOk <= 1'b0;
      case (state)
        cachePkg::cacheIdle: begin
          if (req) begin
            addrOk <= 1'b1;
            state  <= cachePkg::cacheLookup;
          end
        end
        cachePkg::cacheLookup: begin
          if (hit) begin
            state <= cachePkg::cacheRespond;
          end else begin
            refill.req <= 1'b1;
            state      <= cachePkg::cacheRefill;
          end
        end
        cachePkg::cacheRefill: begin
          if (refill.beatValid) begin
            valid[fillIndex] <= 1'b1;
            if (refill.beatLast) begin
              refill.req <= 1'b0;
              state      <= cachePkg::cacheRespond;
            end
          end
        end
        cachePkg::cacheRespond: begin
          dataOk <= 1'b1;
          state  <= cachePkg::cacheIdle;
        end
        default: state <= cachePkg::cacheIdle;
      endcase
    end
  end

  ////////////////////
  // storage and data path
  ////////////////////

  always_ff @(posedge clk) begin
    case (state)
      cachePkg::cacheIdle: begin
        if (req) begin
          reqAddr <= addr;
        end
      end
      cachePkg::cacheLookup: begin
        rdata     <= words[reqIndex];
        // first entry of the block
        fillIndex <= {reqIndex[I_INDEX_W-1:BLOCK_W], {BLOCK_W{1'b0}}};
      end
      cachePkg::cacheRefill: begin
        if (refill.beatValid) begin
          tags[fillIndex]  <= reqTag;
          words[fillIndex] <= refill.beatData;
          fillIndex        <= fillIndex + 1'b1;
          // keep the requested word
          if (fillIndex == reqIndex) begin
            rdata <= refill.beatData;
          end
        end
      end
      default: ;
    endcase
  end

endmodule

/* logic/storeIf.sv */
`timescale 1ns/1ps

interface storeIf;

  logic            valid;
  cachePkg::addrT  addr;
  cachePkg::wordT  data;
  axiPkg::strobeT  strobe;
  // high while a store is in flight on the bus
  logic            busy;

  modport cache (
    output valid, addr, data, strobe,
    input  busy
  );

  modport master (
    input  valid, addr, data, strobe,
    output busy
  );

endinterface

/* logic/refillIf.sv */
`timescale 1ns/1ps

interface refillIf;

  // request side, held until the last beat
  logic           req;
  cachePkg::addrT addr;
  logic           burst;

  // returning beats in address order
  logic           beatValid;
  cachePkg::wordT beatData;
  logic           beatLast;

  modport cache (
    output req, addr, burst,
    input  beatValid, beatData, beatLast
  );

  modport master (
    input  req, addr, burst,
    output beatValid, beatData, beatLast
  );

endinterface

/* logic/cachePkg.sv */
package cachePkg;

  ////////////////////
  // address split
  ////////////////////

  localparam int ADDR_W = 32;

  // byte offset inside one word
  localparam int OFFSET_W = 2;

  typedef logic [ADDR_W-1:0] addrT;
  typedef logic [axiPkg::DATA_W-1:0] wordT;

  ////////////////////
  // request attributes
  ////////////////////

  typedef enum logic [1:0] {
    sizeByte,
    sizeHalf,
    sizeWord
  } accessSizeT;

  // shared by both cache sides
  typedef enum logic [1:0] {
    cacheIdle,
    cacheLookup,
    cacheRefill,
    cacheRespond
  } cacheStateT;

endpackage

/* logic/axiPkg.sv */
package axiPkg;

  localparam int DATA_W = 32;

  // one enable per byte lane
  typedef logic [DATA_W/8-1:0] strobeT;

  // beats minus one, as on ARLEN
  typedef logic [7:0] burstLenT;

  typedef enum logic [1:0] {
    readIdle,
    readAddr,
    readData,
    readStall
  } readStateT;

  typedef enum logic [1:0] {
    writeIdle,
    writeAddr,
    writeData,
    writeResp
  } writeStateT;

endpackage
